/* rv_mem.f */
+incdir+src
src/rv_isa_pkg.sv
src/cache_pkg.sv
src/mem_bus_if.sv
src/data_mem.sv
src/data_cache.sv
src/memory_unit.sv
testbench/memory_unit_tb.sv

/* testbench/memory_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_settings.svh"

module memory_unit_tb;

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_RANDOM  = 1500;
    localparam int NUM_DIRECT  = 200;  // Upper bound on the directed accesses.
    localparam int CYCLE_LIMIT = (NUM_RANDOM + NUM_DIRECT) * (`MISS_LATENCY + 2) + 200;

    logic                     clk;
    logic                     reset;
    logic                     we;
    logic [`XLEN-1:0]         a;
    logic [`XLEN-1:0]         wd;
    rv_isa_pkg::access_size_e addressing_control;
    logic [`XLEN-1:0]         rd;
    logic                     stall;

    logic [`XLEN-1:0] model [`MEM_WORDS];
    int               seed = 32'ha608;
    int               cycle_count = 0;

    logic [2:0] code_list  [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    logic [2:0] store_list [3] = '{3'b000, 3'b001, 3'b010};
    logic [2:0] idle_list  [3] = '{3'b011, 3'b110, 3'b111};

    memory_unit i_memory_unit (
        .clk                (clk),
        .reset              (reset),
        .we                 (we),
        .a                  (a),
        .wd                 (wd),
        .addressing_control (addressing_control),
        .rd                 (rd),
        .stall              (stall)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run passed %0d cycles, stall may never have dropped",
                     CYCLE_LIMIT);
            abort_run();
        end
    end

    // Selects and extends a load field by the RV32 rules.
    function automatic logic [`XLEN-1:0] expected_load(input logic [`XLEN-1:0] word,
                                                       input logic [2:0] code,
                                                       input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (off * 8));
        h = off[1] ? word[31:16] : word[15:0];
        case (code)
            3'b000:  return {{24{b[7]}}, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b010:  return word;
            3'b100:  return {24'b0, b};
            3'b101:  return {16'b0, h};
            default: return '0;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] merge_store(input logic [`XLEN-1:0] old,
                                                     input logic [`XLEN-1:0] data,
                                                     input logic [2:0] code,
                                                     input logic [1:0] off);
        logic [`XLEN-1:0] mask;
        logic [`XLEN-1:0] val;
        case (code)
            3'b000: begin
                mask = 32'h0000_00ff << (off * 8);
                val  = {24'b0, data[7:0]} << (off * 8);
            end
            3'b001: begin
                mask = 32'h0000_ffff << (off[1] * 16);
                val  = {16'b0, data[15:0]} << (off[1] * 16);
            end
            default: begin
                mask = '1;
                val  = data;
            end
        endcase
        return (old & ~mask) | (val & mask);
    endfunction

    // Presents one access and holds it until the edge where stall is low.
    task automatic run_access(input logic w, input logic [9:0] addr,
                              input logic [`XLEN-1:0] data, input logic [2:0] code);
        logic             is_ld;
        logic             is_st;
        logic             done;
        logic             stall_seen;
        logic [`XLEN-1:0] rd_seen;
        logic [`XLEN-1:0] expected;
        is_ld = !w && (code inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
        is_st = w && (code inside {3'b000, 3'b001, 3'b010});
        we = w;
        a = {{(`XLEN-10){1'b0}}, addr};
        wd = data;
        addressing_control = rv_isa_pkg::access_size_e'(code);
        done = 1'b0;
        while (!done) begin
            #(CLK_PERIOD - 2); // Just before the next rising edge.
            rd_seen = rd;
            stall_seen = stall;
            if (!stall_seen) begin
                done = 1'b1;
                if (is_ld) begin
                    expected = expected_load(model[addr[9:2]], code, addr[1:0]);
                    assert (rd_seen === expected) else begin
                        $display("MISMATCH at %0t: load code %b addr %h expected %h got %h",
                                 $time, code, addr, expected, rd_seen);
                        abort_run();
                    end
                end else if (is_st) begin
                    model[addr[9:2]] = merge_store(model[addr[9:2]], data, code, addr[1:0]);
                end else begin
                    assert (rd_seen === '0) else begin
                        $display("MISMATCH at %0t: idle code %b we %b expected rd 0 got %h",
                                 $time, code, w, rd_seen);
                        abort_run();
                    end
                end
            end else begin
                assert (is_ld || is_st) else begin
                    $display("stall went high for the non-access code %b with we %b", code, w);
                    abort_run();
                end
            end
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        logic [9:0]       addr;
        logic [9:0]       other;
        logic [2:0]       code;
        logic             w;
        logic [`XLEN-1:0] data;
        int               r;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            model[i] = '0;
        end
        reset = 1'b1;
        we = 1'b0;
        a = '0;
        wd = '0;
        addressing_control = rv_isa_pkg::access_size_e'(3'b011);
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        #(CLK_PERIOD - 2);
        assert (stall === 1'b0 && rd === '0) else begin
            $display("MISMATCH at %0t: after reset stall %b rd %h, expected 0 and 0",
                     $time, stall, rd);
            abort_run();
        end
        @(posedge clk);
        #1;

        addr = 10'h0a0;
        run_access(1'b1, addr, 32'h1122_3344, 3'b010);
        run_access(1'b0, addr, '0, 3'b010);
        for (int off = 0; off < 4; off++) begin
            run_access(1'b1, addr + 10'(off), 32'h55aa_66a0 + off, 3'b000);
            run_access(1'b0, addr, '0, 3'b010);
        end
        for (int off = 0; off < 4; off += 2) begin
            run_access(1'b1, addr + 10'(off), 32'h1234_8f00 + off, 3'b001);
            run_access(1'b0, addr, '0, 3'b010);
        end

        run_access(1'b1, addr, 32'h8f7e_41c2, 3'b010); // Both signs among bytes and halves.
        foreach (code_list[k]) begin
            for (int off = 0; off < 4; off++) begin
                run_access(1'b0, addr + 10'(off), '0, code_list[k]);
            end
        end

        addr = 10'h044;  // Both share index 1 with tags 1 and 2.
        other = 10'h084;
        for (int i = 0; i < 6; i++) begin
            run_access(1'b1, addr, 32'hc0de_0000 + i, 3'b010);
            run_access(1'b0, other, '0, 3'b010);
            run_access(1'b1, other, 32'hbeef_0000 + i, 3'b010);
            run_access(1'b0, addr, '0, 3'b010);
            run_access(1'b0, other, '0, 3'b010);
        end

        addr = 10'h0a0;
        foreach (idle_list[k]) begin
            run_access(1'b0, addr, 32'hdead_beef, idle_list[k]);
            run_access(1'b1, addr, 32'hdead_beef, idle_list[k]);
        end
        run_access(1'b1, addr, 32'hdead_beef, 3'b100);
        run_access(1'b1, addr, 32'hdead_beef, 3'b101);
        run_access(1'b0, addr, '0, 3'b010);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            r = $random(seed);
            w = r[0];
            addr = {4'(r[3:2]), 4'(r[5:4]), r[7:6]}; // Four tags over four indices.
            data = $random(seed);
            code = w ? store_list[r[9:8] % 3] : code_list[r[12:10] % 5];
            run_access(w, addr, data, code);
        end

        we = 1'b0;
        addressing_control = rv_isa_pkg::access_size_e'(3'b011);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* src/memory_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_settings.svh"

module memory_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     we,
    input  logic [`XLEN-1:0]         a,
    input  logic [`XLEN-1:0]         wd,
    input  rv_isa_pkg::access_size_e addressing_control,
    output logic [`XLEN-1:0]         rd,
    output logic                     stall
);

    localparam int BYTE_ADDR_W = $clog2(`MEM_WORDS) + 2;

    cache_pkg::mem_word_t cache_dout;
    logic [7:0]           load_byte;
    logic [15:0]          load_half;

    mem_bus_if i_mem_bus (
        .clk (clk)
    );

    data_cache i_data_cache (
        .clk                (clk),
        .reset              (reset),
        .a                  (a),
        .wd                 (wd),
        .we                 (we),
        .addressing_control (addressing_control),
        .cache_dout         (cache_dout),
        .stall              (stall),
        .mem                (i_mem_bus.cache)
    );

    data_mem i_data_mem (
        .clk (clk),
        .mem (i_mem_bus.memory)
    );

    assign load_byte = cache_dout[{a[1:0], 3'b000} +: 8];
    assign load_half = cache_dout[{a[1], 4'b0000} +: 16];

    // Signed loads copy the field's top bit upward.
    always_comb begin
        case (addressing_control)
            rv_isa_pkg::SIZE_B:  rd = {{(`XLEN-8){load_byte[7]}}, load_byte};
            rv_isa_pkg::SIZE_H:  rd = {{(`XLEN-16){load_half[15]}}, load_half};
            rv_isa_pkg::SIZE_W:  rd = cache_dout;
            rv_isa_pkg::SIZE_BU: rd = {{(`XLEN-8){1'b0}}, load_byte};
            rv_isa_pkg::SIZE_HU: rd = {{(`XLEN-16){1'b0}}, load_half};
            default:             rd = '0;
        endcase
    end

    // The cache tag stops at bit 9, so higher bits would alias silently.
    a_addr_in_range: assert property (
        @(posedge clk) disable iff (reset)
        (rv_isa_pkg::is_load(we, addressing_control) ||
         rv_isa_pkg::is_store(we, addressing_control))
        |-> (a[`XLEN-1:BYTE_ADDR_W] == '0)
    ) else $error("memory_unit access to %0h beyond the data memory", a);

endmodule

`default_nettype wire

/* src/data_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_settings.svh"

module data_cache (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`XLEN-1:0]         a,
    input  logic [`XLEN-1:0]         wd,
    input  logic                     we,
    input  rv_isa_pkg::access_size_e addressing_control,
    output cache_pkg::mem_word_t     cache_dout,
    output logic                     stall,
    mem_bus_if.cache                 mem
);

    localparam int ADDR_W = $clog2(`MEM_WORDS);
    localparam int IDX_W  = $clog2(`CACHE_LINES);
    localparam int TAG_W  = ADDR_W - IDX_W;
    localparam int CNT_W  = $clog2(`MISS_LATENCY + 1);

    logic                   [`CACHE_LINES-1:0] valid;
    logic [TAG_W-1:0]       tag_ram  [`CACHE_LINES];
    cache_pkg::mem_word_t   data_ram [`CACHE_LINES];

    cache_pkg::cache_state_e state;
    logic [CNT_W-1:0]        fill_count;

    logic [IDX_W-1:0]     index;
    logic [TAG_W-1:0]     tag;
    logic                 load;
    logic                 store;
    logic                 access;
    logic                 hit;
    logic                 store_hit;
    logic                 fill_done;
    cache_pkg::mem_word_t merged;

    assign index = a[IDX_W+1:2];
    assign tag   = a[ADDR_W+1:IDX_W+2];

    assign load   = rv_isa_pkg::is_load(we, addressing_control);
    assign store  = rv_isa_pkg::is_store(we, addressing_control);
    assign access = load || store;

    assign hit       = valid[index] && (tag_ram[index] == tag);
    assign store_hit = store && hit;
    assign fill_done = (state == cache_pkg::FILL) && (fill_count == CNT_W'(`MISS_LATENCY - 1));

    // The core holds its request until this drops.
    assign stall = (state == cache_pkg::FILL) || (access && !hit);

    assign cache_dout = load ? data_ram[index] : '0;

    // Store data lands on its byte lane inside the cached word.
    always_comb begin
        merged = data_ram[index];
        case (addressing_control)
            rv_isa_pkg::SIZE_B: merged[{a[1:0], 3'b000} +: 8]  = wd[7:0];
            rv_isa_pkg::SIZE_H: merged[{a[1], 4'b0000} +: 16]  = wd[15:0];
            rv_isa_pkg::SIZE_W: merged = wd;
            default:            merged = data_ram[index];
        endcase
    end

    // The backing store sees every store hit since the cache writes through.
    assign mem.addr  = a[`XLEN-1:2];
    assign mem.wdata = merged;
    assign mem.we    = store_hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= cache_pkg::LOOKUP;
            fill_count <= '0;
            valid      <= '0;
        end else begin
            case (state)
                cache_pkg::LOOKUP: begin
                    if (access && !hit) begin
                        state      <= cache_pkg::FILL; // Store misses allocate too.
                        fill_count <= '0;
                    end
                end
                cache_pkg::FILL: begin
                    if (fill_done) begin
                        state        <= cache_pkg::LOOKUP;
                        valid[index] <= 1'b1;
                    end else begin
                        fill_count <= fill_count + 1'b1;
                    end
                end
                default: state <= cache_pkg::LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            data_ram[index] <= mem.rdata; // The address has been steady since the miss.
            tag_ram[index]  <= tag;
        end else if (store_hit) begin
            data_ram[index] <= merged;
        end
    end

    // A write during a fill would race the line being refilled.
    a_no_write_in_fill: assert property (
        @(posedge clk) disable iff (reset)
        (state == cache_pkg::FILL) |-> !mem.we
    ) else $error("data_cache wrote the backing store during FILL");

    a_idle_no_stall: assert property (
        @(posedge clk) disable iff (reset)
        !access |-> !stall
    ) else $error("data_cache stalled with no access presented");

endmodule

`default_nettype wire

/* src/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_settings.svh"

module data_mem (
    input logic       clk,
    mem_bus_if.memory mem
);

    localparam int ADDR_W = $clog2(`MEM_WORDS);

    cache_pkg::mem_word_t ram [`MEM_WORDS];
    logic [ADDR_W-1:0]    word_addr;

    // Upper word address bits fall outside the memory and are ignored.
    assign word_addr = mem.addr[ADDR_W-1:0];

    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            ram[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (mem.we) begin
            ram[word_addr] <= mem.wdata;
        end
    end

    always_ff @(posedge clk) begin
        mem.rdata <= ram[word_addr]; // Old word on a same-cycle write.
    end

    // A write beyond the array would silently alias onto a lower word.
    a_write_in_range: assert property (
        @(posedge clk) mem.we |-> (mem.addr < `MEM_WORDS)
    ) else $error("data_mem write to word %0h past MEM_WORDS", mem.addr);

endmodule

`default_nettype wire

/* src/mem_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_settings.svh"

interface mem_bus_if (
    input logic clk
);

    logic [`XLEN-3:0]     addr;  // Word address without the byte offset.
    cache_pkg::mem_word_t wdata;
    logic                 we;    // Write strobe, one cycle per store.
    cache_pkg::mem_word_t rdata; // Word at the address of the previous edge.

    modport cache (
        input  clk,
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport memory (
        input  clk,
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

`default_nettype wire

/* src/cache_pkg.sv */
`default_nettype none

`include "rv_mem_settings.svh"

package cache_pkg;

    // One cache line and one backing store word have the same shape.
    typedef logic [`XLEN-1:0] mem_word_t;

    // LOOKUP serves hits; FILL waits on the backing store after a miss.
    typedef enum logic {
        LOOKUP = 1'b0,
        FILL   = 1'b1
    } cache_state_e;

endpackage

`default_nettype wire

/* src/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // Encoded on funct3 of the RISC-V load and store opcodes.
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } access_size_e;

    function automatic logic is_load(input logic we, input access_size_e size);
        return !we && (size inside {SIZE_B, SIZE_H, SIZE_W, SIZE_BU, SIZE_HU});
    endfunction

    // Stores have no unsigned forms.
    function automatic logic is_store(input logic we, input access_size_e size);
        return we && (size inside {SIZE_B, SIZE_H, SIZE_W});
    endfunction

endpackage

`default_nettype wire

/* src/rv_mem_settings.svh */
`ifndef RV_MEM_SETTINGS_SVH
`define RV_MEM_SETTINGS_SVH

// Data word width. The load formatter assumes RV32.
`define XLEN 32

// Backing store depth in words, a 1 KiB byte space.
`define MEM_WORDS 256

// One word per line.
`define CACHE_LINES 16

// Fill wait in cycles, counting the registered RAM read.
`define MISS_LATENCY 2

`endif
